/* src/fpAddPkg.sv */
// Shared types: operand and datapath structs, FSM and opcode enums, register map.
`default_nettype none

package fpAddPkg;

    // ------------------------------------------------------------------
    // datapath structs.
    // ------------------------------------------------------------------
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [23:0] significand;
    } fpOperandT;

    // sigA always belongs to the operand with the larger or equal exponent.
    typedef struct packed {
        logic        signA;
        logic        signB;
        logic [7:0]  exponent;
        logic [23:0] sigA;
        logic [23:0] sigB;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic        shiftedB;
    } alignedPairT;

    typedef struct packed {
        logic        sign;
        logic        carry;
        logic [23:0] significand;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic [7:0]  exponent;
    } aluResultT;

    // ------------------------------------------------------------------
    // control encodings.
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        stIdle,
        stUnpack,
        stAlign,
        stAdd,
        stNormalize,
        stRound,
        stDone
    } ctrlStateT;

    typedef enum logic {
        opAdd = 1'b0,
        opSub = 1'b1
    } opcodeT;

    // register word addresses.
    localparam int unsigned regOperandA = 0;
    localparam int unsigned regOperandB = 1;
    localparam int unsigned regControl  = 2;
    localparam int unsigned regStatus   = 3;
    localparam int unsigned regResult   = 4;

endpackage

`default_nettype wire

/* src/fpWishboneSlave.sv */
// Wishbone classic slave with operand, control, status and result registers.
`timescale 1ns/10ps
`default_nettype none

module fpWishboneSlave import fpAddPkg::*; #(
    parameter int wbAddrWidth = 3
) (
    input  wire logic                   clock,
    input  wire logic                   arstN,
    input  wire logic [wbAddrWidth-1:0] wbAdr,
    input  wire logic [31:0]            wbDatW,
    output logic [31:0]                 wbDatR,
    input  wire logic                   wbWe,
    input  wire logic [3:0]             wbSel,
    input  wire logic                   wbStb,
    input  wire logic                   wbCyc,
    output logic                        wbAck,
    output logic                        start,
    output opcodeT                      opcode,
    output logic [31:0]                 operandA,
    output logic [31:0]                 operandB,
    input  wire logic                   busy,
    input  wire logic                   resultValid,
    input  wire logic [31:0]            result
);

    logic        access;
    logic        writeEn;
    logic        startReq;
    logic        done;
    logic [31:0] resultReg;

    // one access per strobe, the cycle after ack is never re-acknowledged.
    assign access   = wbStb & wbCyc & ~wbAck;
    // every register is a full word.
    assign writeEn  = access & wbWe;
    assign startReq = writeEn & (wbAdr == wbAddrWidth'(regControl)) & wbDatW[0] & ~busy;

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            wbAck  <= 1'b0;
            start  <= 1'b0;
            done   <= 1'b0;
            opcode <= opAdd;
        end
        else
        begin
            wbAck <= access;
            start <= startReq;
            if (startReq)
            begin
                opcode <= opcodeT'(wbDatW[1]);
                done   <= 1'b0;
            end
            else if (resultValid)
                done <= 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (writeEn && wbAdr == wbAddrWidth'(regOperandA))
            operandA <= wbDatW;
        if (writeEn && wbAdr == wbAddrWidth'(regOperandB))
            operandB <= wbDatW;
        if (resultValid)
            resultReg <= result;
        if (access && !wbWe)
        begin
            case (wbAdr)
                wbAddrWidth'(regOperandA): wbDatR <= operandA;
                wbAddrWidth'(regOperandB): wbDatR <= operandB;
                wbAddrWidth'(regControl):  wbDatR <= {30'b0, opcode, 1'b0};
                wbAddrWidth'(regStatus):   wbDatR <= {30'b0, done, busy};
                wbAddrWidth'(regResult):   wbDatR <= resultReg;
                default:                   wbDatR <= 32'h0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/fpAddControl.sv */
// FSM sequencing unpack, align, add, normalize and round.
`timescale 1ns/10ps
`default_nettype none

module fpAddControl import fpAddPkg::*; #(
    parameter int countWidth = 5
) (
    input  wire logic             clock,
    input  wire logic             arstN,
    input  wire logic             start,
    input  wire opcodeT           opcode,
    input  wire logic             countZero,
    input  wire logic             normalized,
    output logic                  unpackEn,
    output logic                  alignStep,
    output logic                  aluEn,
    output logic                  normStep,
    output logic                  roundEn,
    output logic                  loadCount,
    output logic [countWidth-1:0] countValue,
    input  wire logic [7:0]       alignDiff,
    output logic                  busy,
    output logic                  invertB
);

    localparam int unsigned maxShift = 26;

    ctrlStateT  state;
    ctrlStateT  nextState;
    logic       settle;
    logic [7:0] cappedDiff;

    assign cappedDiff = (alignDiff > 8'(maxShift)) ? 8'(maxShift) : alignDiff;
    assign busy       = (state != stIdle);

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            state   <= stIdle;
            settle  <= 1'b0;
            invertB <= 1'b0;
        end
        else
        begin
            state  <= nextState;
            // the normalizer picks up the ALU register one cycle after the add.
            settle <= (state == stAdd);
            if (state == stIdle && start)
                invertB <= (opcode == opSub);
        end
    end

    always_comb
    begin
        nextState  = state;
        unpackEn   = 1'b0;
        alignStep  = 1'b0;
        aluEn      = 1'b0;
        normStep   = 1'b0;
        roundEn    = 1'b0;
        loadCount  = 1'b0;
        countValue = '0;

        case (state)
            stIdle:
                if (start)
                    nextState = stUnpack;
            stUnpack:
            begin
                unpackEn   = 1'b1;
                loadCount  = 1'b1;
                // loaded one short so the last step sees countZero.
                countValue = countWidth'(cappedDiff - 8'd1);
                nextState  = (cappedDiff == 8'd0) ? stAdd : stAlign;
            end
            stAlign:
            begin
                alignStep = 1'b1;
                if (countZero)
                    nextState = stAdd;
            end
            stAdd:
            begin
                aluEn      = 1'b1;
                loadCount  = 1'b1;
                countValue = countWidth'(maxShift);
                nextState  = stNormalize;
            end
            stNormalize:
                if (!settle)
                begin
                    if (normalized || countZero)
                        nextState = stRound;
                    else
                        normStep = 1'b1;
                end
            stRound:
            begin
                roundEn   = 1'b1;
                nextState = stDone;
            end
            default:
                nextState = stIdle;
        endcase
    end

endmodule

`default_nettype wire

/* src/shiftCounter.sv */
// Loadable down-counter for the align and normalize phases.
`timescale 1ns/10ps
`default_nettype none

module shiftCounter #(
    parameter int countWidth = 5
) (
    input  wire logic                  clock,
    input  wire logic                  arstN,
    input  wire logic                  load,
    input  wire logic [countWidth-1:0] loadValue,
    input  wire logic                  decrement,
    output logic                       countZero
);

    logic [countWidth-1:0] count;

    assign countZero = (count == '0);

    // holds at zero once it gets there.
    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
            count <= '0;
        else if (load)
            count <= loadValue;
        else if (decrement && !countZero)
            count <= count - 1'b1;
    end

endmodule

`default_nettype wire

/* src/operandAligner.sv */
// Operand unpack, ordering and right-shift alignment of the smaller significand.
`timescale 1ns/10ps
`default_nettype none

module operandAligner import fpAddPkg::*; (
    input  wire logic        clock,
    input  wire logic        arstN,
    input  wire logic        unpackEn,
    input  wire logic        alignStep,
    input  wire logic        invertB,
    input  wire logic [31:0] operandA,
    input  wire logic [31:0] operandB,
    output logic [7:0]       alignDiff,
    output alignedPairT      pair
);

    fpOperandT opA;
    fpOperandT opB;
    fpOperandT opHi;
    fpOperandT opLo;
    logic      swap;

    always_comb
    begin
        opA.sign        = operandA[31];
        opA.exponent    = operandA[30:23];
        // zero exponent is treated as zero, no subnormals.
        opA.significand = (operandA[30:23] == 8'd0) ? 24'd0 : {1'b1, operandA[22:0]};
        opB.sign        = operandB[31] ^ invertB;
        opB.exponent    = operandB[30:23];
        opB.significand = (operandB[30:23] == 8'd0) ? 24'd0 : {1'b1, operandB[22:0]};

        swap      = (opB.exponent > opA.exponent);
        opHi      = swap ? opB : opA;
        opLo      = swap ? opA : opB;
        alignDiff = opHi.exponent - opLo.exponent;
    end

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
            pair <= '0;
        else if (unpackEn)
        begin
            pair.signA     <= opHi.sign;
            pair.signB     <= opLo.sign;
            pair.exponent  <= opHi.exponent;
            pair.sigA      <= opHi.significand;
            pair.sigB      <= opLo.significand;
            pair.guardBit  <= 1'b0;
            pair.roundBit  <= 1'b0;
            pair.stickyBit <= 1'b0;
            pair.shiftedB  <= 1'b0;
        end
        else if (alignStep)
        begin
            // bits fall through guard and round and collect in sticky.
            {pair.sigB, pair.guardBit, pair.roundBit} <= {1'b0, pair.sigB, pair.guardBit};
            pair.stickyBit <= pair.roundBit | pair.stickyBit;
            pair.shiftedB  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/mantissaAlu.sv */
// Sign-magnitude add and subtract of the aligned significands.
`timescale 1ns/10ps
`default_nettype none

module mantissaAlu import fpAddPkg::*; (
    input  wire logic  clock,
    input  wire logic  arstN,
    input  wire logic  aluEn,
    input  wire alignedPairT pair,
    output aluResultT  result
);

    logic [26:0] extA;
    logic [26:0] extB;
    logic [27:0] sum;
    logic        sumSign;

    always_comb
    begin
        // the shifted operand carries guard, round and sticky below its lsb.
        extA = pair.shiftedB ? {pair.sigA, 3'b000}
                             : {pair.sigA, pair.guardBit, pair.roundBit, pair.stickyBit};
        extB = pair.shiftedB ? {pair.sigB, pair.guardBit, pair.roundBit, pair.stickyBit}
                             : {pair.sigB, 3'b000};

        if (pair.signA == pair.signB)
        begin
            sum     = {1'b0, extA} + {1'b0, extB};
            sumSign = pair.signA;
        end
        else if (extA >= extB)
        begin
            sum     = {1'b0, extA - extB};
            sumSign = pair.signA;
        end
        else
        begin
            sum     = {1'b0, extB - extA};
            sumSign = pair.signB;
        end
    end

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
            result <= '0;
        else if (aluEn)
        begin
            result.sign        <= sumSign;
            result.carry       <= sum[27];
            result.significand <= sum[26:3];
            result.guardBit    <= sum[2];
            result.roundBit    <= sum[1];
            result.stickyBit   <= sum[0];
            result.exponent    <= pair.exponent;
        end
    end

endmodule

`default_nettype wire

/* src/resultNormalizer.sv */
// Left-shift normalization, round to nearest-even and IEEE packing.
`timescale 1ns/10ps
`default_nettype none

module resultNormalizer import fpAddPkg::*; (
    input  wire logic  clock,
    input  wire logic  arstN,
    input  wire logic  aluEn,
    input  wire logic  normStep,
    input  wire logic  roundEn,
    input  wire aluResultT aluIn,
    output logic       normalized,
    output logic       resultValid,
    output logic [31:0] result
);

    logic        captureEn;
    logic        sign;
    // two spare bits so overflow and underflow stay visible.
    logic [9:0]  exponent;
    logic [23:0] sig;
    logic        guardBit;
    logic        roundBit;
    logic        stickyBit;

    logic        roundUp;
    logic [24:0] rounded;
    logic [23:0] roundSig;
    logic [9:0]  roundExp;
    logic [31:0] packedWord;

    assign normalized = sig[23];

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            captureEn   <= 1'b0;
            resultValid <= 1'b0;
        end
        else
        begin
            // the ALU register is valid one cycle after aluEn.
            captureEn   <= aluEn;
            resultValid <= roundEn;
        end
    end

    // ------------------------------------------------------------------
    // working register.
    // ------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (captureEn)
        begin
            sign <= aluIn.sign;
            if (aluIn.carry)
            begin
                sig       <= {1'b1, aluIn.significand[23:1]};
                guardBit  <= aluIn.significand[0];
                roundBit  <= aluIn.guardBit;
                stickyBit <= aluIn.roundBit | aluIn.stickyBit;
                exponent  <= {2'b00, aluIn.exponent} + 10'd1;
            end
            else
            begin
                sig       <= aluIn.significand;
                guardBit  <= aluIn.guardBit;
                roundBit  <= aluIn.roundBit;
                stickyBit <= aluIn.stickyBit;
                exponent  <= {2'b00, aluIn.exponent};
            end
        end
        else if (normStep)
        begin
            {sig, guardBit, roundBit} <= {sig[22:0], guardBit, roundBit, 1'b0};
            exponent <= exponent - 10'd1;
        end

        if (roundEn)
            result <= packedWord;
    end

    // ------------------------------------------------------------------
    // rounding and packing.
    // ------------------------------------------------------------------
    always_comb
    begin
        roundUp  = guardBit & (roundBit | stickyBit | sig[0]);
        rounded  = {1'b0, sig} + {24'd0, roundUp};
        roundSig = rounded[23:0];
        roundExp = exponent;
        if (rounded[24])
        begin
            roundSig = rounded[24:1];
            roundExp = exponent + 10'd1;
        end

        if (!roundSig[23])
            packedWord = 32'h0;
        else if ($signed(roundExp) >= 10'sd255)
            packedWord = {sign, 8'hFF, 23'd0};
        else if ($signed(roundExp) <= 10'sd0)
            packedWord = {sign, 31'd0};
        else
            packedWord = {sign, roundExp[7:0], roundSig[22:0]};
    end

endmodule

`default_nettype wire

/* src/fpAddUnit.sv */
// Top level of the floating-point add unit with its Wishbone slave port.
`timescale 1ns/10ps
`default_nettype none

module fpAddUnit import fpAddPkg::*; #(
    parameter int wbAddrWidth = 3,
    parameter int countWidth  = 5
) (
    input  wire logic                   clock,
    input  wire logic                   arstN,
    input  wire logic [wbAddrWidth-1:0] wbAdr,
    input  wire logic [31:0]            wbDatW,
    output logic [31:0]                 wbDatR,
    input  wire logic                   wbWe,
    input  wire logic [3:0]             wbSel,
    input  wire logic                   wbStb,
    input  wire logic                   wbCyc,
    output logic                        wbAck
);

    logic                  start;
    opcodeT                opcode;
    logic [31:0]           operandA;
    logic [31:0]           operandB;
    logic                  busy;
    logic                  resultValid;
    logic [31:0]           result;
    logic                  unpackEn;
    logic                  alignStep;
    logic                  aluEn;
    logic                  normStep;
    logic                  roundEn;
    logic                  loadCount;
    logic [countWidth-1:0] countValue;
    logic                  countZero;
    logic                  normalized;
    logic [7:0]            alignDiff;
    logic                  invertB;
    alignedPairT           pair;
    aluResultT             aluOut;

    fpWishboneSlave #(.wbAddrWidth(wbAddrWidth)) fpWishboneSlave_inst (
        .clock, .arstN, .wbAdr, .wbDatW, .wbDatR, .wbWe, .wbSel, .wbStb, .wbCyc, .wbAck,
        .start, .opcode, .operandA, .operandB, .busy, .resultValid, .result
    );

    fpAddControl #(.countWidth(countWidth)) fpAddControl_inst (
        .clock, .arstN, .start, .opcode, .countZero, .normalized,
        .unpackEn, .alignStep, .aluEn, .normStep, .roundEn,
        .loadCount, .countValue, .alignDiff, .busy, .invertB
    );

    shiftCounter #(.countWidth(countWidth)) shiftCounter_inst (
        .clock, .arstN,
        .load      (loadCount),
        .loadValue (countValue),
        .decrement (alignStep | normStep),
        .countZero
    );

    operandAligner operandAligner_inst (
        .clock, .arstN, .unpackEn, .alignStep, .invertB,
        .operandA, .operandB, .alignDiff, .pair
    );

    mantissaAlu mantissaAlu_inst (
        .clock, .arstN, .aluEn, .pair,
        .result (aluOut)
    );

    resultNormalizer resultNormalizer_inst (
        .clock, .arstN, .aluEn, .normStep, .roundEn,
        .aluIn (aluOut),
        .normalized, .resultValid, .result
    );

endmodule

`default_nettype wire

/* verification/fpAddUnitTb.sv */
// Floating-point add unit testbench: Wishbone driver tasks, test table, checks and watchdog.
`timescale 1ns/10ps
`default_nettype none

module fpAddUnitTb import fpAddPkg::*; ();

    localparam int addrWidth      = 3;
    localparam int resetCycles    = 16;
    localparam int cyclesPerTest  = 80;
    localparam int ackLimit       = 4;
    localparam int pollLimit      = 60;

    typedef struct packed {
        logic [31:0] opA;
        logic [31:0] opB;
        opcodeT      op;
        logic [31:0] expected;
    } caseT;

    logic                 clock;
    logic                 arstN;
    logic [addrWidth-1:0] wbAdr;
    logic [31:0]          wbDatW;
    logic [31:0]          wbDatR;
    logic                 wbWe;
    logic [3:0]           wbSel;
    logic                 wbStb;
    logic                 wbCyc;
    logic                 wbAck;

    caseT  cases[$];
    string caseNames[$];
    int    watchdogCycles = 0;

    fpAddUnit #(.wbAddrWidth(addrWidth), .countWidth(5)) fpAddUnit_inst (
        .clock, .arstN, .wbAdr, .wbDatW, .wbDatR, .wbWe, .wbSel, .wbStb, .wbCyc, .wbAck
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // ------------------------------------------------------------------
    // helpers.
    // ------------------------------------------------------------------
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else abortRun($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
    endtask

    // called 1 ns after an edge, returns 1 ns after the acknowledging edge.
    task automatic waitAck();
        int cycles;
        cycles = 0;
        @(posedge clock);
        #1;
        while (!wbAck && cycles < ackLimit)
        begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!wbAck)
            abortRun("bus access was never acknowledged");
    endtask

    task automatic wbWrite(input int unsigned addr, input logic [31:0] data);
        wbAdr  = addrWidth'(addr);
        wbDatW = data;
        wbWe   = 1'b1;
        wbSel  = 4'hF;
        wbStb  = 1'b1;
        wbCyc  = 1'b1;
        waitAck();
        wbStb  = 1'b0;
        wbCyc  = 1'b0;
        wbWe   = 1'b0;
    endtask

    task automatic wbRead(input int unsigned addr, output logic [31:0] data);
        wbAdr = addrWidth'(addr);
        wbWe  = 1'b0;
        wbStb = 1'b1;
        wbCyc = 1'b1;
        waitAck();
        data  = wbDatR;
        wbStb = 1'b0;
        wbCyc = 1'b0;
    endtask

    task automatic startOperation(input logic [31:0] a, input logic [31:0] b, input opcodeT op);
        wbWrite(regOperandA, a);
        wbWrite(regOperandB, b);
        wbWrite(regControl, {30'b0, op, 1'b1});
    endtask

    task automatic waitDone(input string name, output logic [31:0] status);
        int polls;
        polls = 0;
        wbRead(regStatus, status);
        while (!status[1] && polls < pollLimit)
        begin
            wbRead(regStatus, status);
            polls++;
        end
        if (!status[1])
            abortRun($sformatf("done bit never set in test %s", name));
    endtask

    task automatic addCase(input string name, input logic [31:0] a, input logic [31:0] b,
                           input opcodeT op, input logic [31:0] expected);
        caseT entry;
        entry.opA      = a;
        entry.opB      = b;
        entry.op       = op;
        entry.expected = expected;
        cases.push_back(entry);
        caseNames.push_back(name);
    endtask

    // expected words worked out by hand, round to nearest-even, no subnormals.
    task automatic buildTable();
        addCase("addCarry",       32'h3FC00000, 32'h3FC00000, opAdd, 32'h40400000);
        addCase("addGap1",        32'h3F800000, 32'h40000000, opAdd, 32'h40400000);
        addCase("addStickyOnly",  32'h3F800000, 32'h30800000, opAdd, 32'h3F800000);
        addCase("carryToPow2",    32'h4B7FFFFF, 32'h3F800000, opAdd, 32'h4B800000);
        addCase("subLarger",      32'h3F800000, 32'h40400000, opSub, 32'hC0000000);
        addCase("mixedSigns",     32'h40A00000, 32'hC0000000, opAdd, 32'h40400000);
        addCase("subNegOperand",  32'hC0000000, 32'h40A00000, opSub, 32'hC0E00000);
        addCase("cancelDeep",     32'h3F800001, 32'h3F800000, opSub, 32'h34000000);
        addCase("cancelNeg",      32'h3F800000, 32'hBF800001, opAdd, 32'hB4000000);
        addCase("subGuardOnly",   32'h3F800000, 32'h3F7FFFFF, opSub, 32'h33800000);
        addCase("subSticky",      32'h3F800000, 32'h30800000, opSub, 32'h3F800000);
        addCase("equalSub",       32'h40200000, 32'h40200000, opSub, 32'h00000000);
        addCase("equalNegAdd",    32'hC0200000, 32'h40200000, opAdd, 32'h00000000);
        addCase("tieEvenDown",    32'h3F800000, 32'h33800000, opAdd, 32'h3F800000);
        addCase("tieEvenUp",      32'h3F800001, 32'h33800000, opAdd, 32'h3F800002);
        addCase("roundCarry",     32'h3F7FFFFF, 32'h33000000, opAdd, 32'h3F800000);
        addCase("zeroOperand",    32'h40490FDB, 32'h00000000, opAdd, 32'h40490FDB);
        addCase("flushSubnormal", 32'h00123456, 32'h3F800000, opAdd, 32'h3F800000);
        addCase("overflowPos",    32'h7F7FFFFF, 32'h7F7FFFFF, opAdd, 32'h7F800000);
        addCase("overflowNeg",    32'hFF7FFFFF, 32'hFF7FFFFF, opAdd, 32'hFF800000);
        addCase("overflowSub",    32'h7F7FFFFF, 32'hFF7FFFFF, opSub, 32'h7F800000);
    endtask

    // ------------------------------------------------------------------
    // main sequence.
    // ------------------------------------------------------------------
    initial
    begin
        logic [31:0] status;
        logic [31:0] readData;
        logic [31:0] wordA;
        logic [31:0] wordB;

        arstN  = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        wbWe   = 1'b0;
        wbSel  = 4'h0;
        wbStb  = 1'b0;
        wbCyc  = 1'b0;
        void'($urandom(77483));

        buildTable();
        // the register phase and the two protocol runs count as three more tests.
        watchdogCycles = (cases.size() + 3) * cyclesPerTest + resetCycles;

        repeat (resetCycles) @(posedge clock);
        #1;
        arstN = 1'b1;

        wbRead(regStatus, status);
        checkEqual("statusAfterReset", 32'h0, status);
        for (int i = 0; i < 3; i++)
        begin
            wordA = $urandom;
            wordB = $urandom;
            wbWrite(regOperandA, wordA);
            wbWrite(regOperandB, wordB);
            wbRead(regOperandA, readData);
            checkEqual("readbackA", wordA, readData);
            wbRead(regOperandB, readData);
            checkEqual("readbackB", wordB, readData);
        end

        for (int i = 0; i < cases.size(); i++)
        begin
            startOperation(cases[i].opA, cases[i].opB, cases[i].op);
            waitDone(caseNames[i], status);
            wbRead(regResult, readData);
            checkEqual(caseNames[i], cases[i].expected, readData);
        end

        // a start while busy must leave the latched opcode and the running add alone.
        startOperation(32'h3FC00000, 32'h3FC00000, opAdd);
        wbWrite(regControl, {30'b0, opSub, 1'b1});
        wbRead(regControl, readData);
        checkEqual("opcodeWhileBusy", 32'h0, readData);
        waitDone("startWhileBusy", status);
        checkEqual("statusWhenDone", 32'h2, status);
        wbRead(regResult, readData);
        checkEqual("startWhileBusy", 32'h40400000, readData);

        // done clears as soon as the next start is taken.
        wbWrite(regControl, {30'b0, opSub, 1'b1});
        wbRead(regStatus, status);
        checkEqual("doneClearsOnStart", 32'h1, status);
        waitDone("restart", status);
        wbRead(regResult, readData);
        checkEqual("restart", 32'h00000000, readData);

        $display("SIMULATION PASSED");
        $finish;
    end

    initial
    begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clock);
        abortRun($sformatf("watchdog expired after %0d cycles", watchdogCycles));
    end

endmodule

`default_nettype wire

/* tb.f */
src/fpAddPkg.sv
src/fpWishboneSlave.sv
src/fpAddControl.sv
src/shiftCounter.sv
src/operandAligner.sv
src/mantissaAlu.sv
src/resultNormalizer.sv
src/fpAddUnit.sv
verification/fpAddUnitTb.sv

/* Makefile */
# Verilator build for the floating-point add unit testbench.

VERILATOR ?= verilator
TOP       ?= fpAddUnitTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
